/* Makefile */
# Verilator build and run of the multi-flow FIFO testbench

TOP = fifo2nfifo_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "ERRORS FOUND" >> $(LOG)
	@cat $(LOG)
	@! grep -q "ERRORS FOUND" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* fifo2nfifo.sv */
/*
 * FIFO to multi-flow buffer
 * One write port into per-flow queues held in a shared memory,
 * round-robin access of the flow readers to its single read port
 */

`timescale 1ns/10ps
`include "nfifo_defs.svh"

module fifo2nfifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  nfifo_pkg::wr_req_t     wr,
  output logic                   full,
  input  nfifo_pkg::flow_mask_t  read,
  output nfifo_pkg::data_vec_t   data_out,
  output nfifo_pkg::flow_mask_t  data_vld,
  output nfifo_pkg::flow_mask_t  empty,
  output nfifo_pkg::status_vec_t status
);

  nfifo_pkg::flow_mask_t eligible;
  nfifo_pkg::flow_mask_t grant;
  logic                  wr_en;
  logic                  rd_en;
  nfifo_pkg::buf_addr_t  wr_addr;
  nfifo_pkg::buf_addr_t  rd_addr;
  nfifo_pkg::rd_resp_t   rd_resp;
  // High while rd_resp holds a fresh word
  logic                  resp_vld_q;

  // ----------------------------------------
  // Control and storage
  // ----------------------------------------
  nfifo_ptr_ctrl u_ptr_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .grant    (grant),
    .read     (read),
    .eligible (eligible),
    .full     (full),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .empty    (empty),
    .status   (status)
  );

  nfifo_rd_arbiter u_rd_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .eligible (eligible),
    .grant    (grant)
  );

  // Write data comes straight from the port
  nfifo_buffer u_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr.data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_resp (rd_resp)
  );

  // ----------------------------------------
  // Output steering
  // ----------------------------------------
  // Valid follows the grant by one cycle, same as the buffer read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_vld_q <= 1'b0;
    end else begin
      resp_vld_q <= rd_en;
    end
  end

  // Word lands on its own flow slice only
  for (genvar i = 0; i < `NFIFO_FLOWS; i++) begin : g_steer
    assign data_vld[i] = resp_vld_q && (rd_resp.flow == nfifo_pkg::flow_t'(i));
    assign data_out[i] = (rd_resp.flow == nfifo_pkg::flow_t'(i)) ? rd_resp.data : '0;
  end

endmodule

/* fifo2nfifo_properties.sv */
/*
 * Output assertions for the FIFO to multi-flow buffer
 * Bound to the top level from the testbench
 */

`timescale 1ns/10ps
`include "nfifo_defs.svh"

module fifo2nfifo_properties (
  input logic                   clk,
  input logic                   rst_n,
  input nfifo_pkg::flow_mask_t  grant,
  input nfifo_pkg::flow_mask_t  data_vld,
  input nfifo_pkg::flow_mask_t  empty,
  input nfifo_pkg::status_vec_t status
);

  // Single read port, at most one word out per cycle, one cycle after its grant
  vld_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(data_vld) && (data_vld == $past(grant)))
    else $error("data_vld %b is not one-hot or does not follow the last grant", data_vld);

  // Granted flow had data at the grant edge
  vld_after_data: assert property (@(posedge clk) disable iff (!rst_n)
    (data_vld & $past(empty)) == '0)
    else $error("data_vld %b on a flow that was empty", data_vld);

  // Count never passes the block size
  for (genvar i = 0; i < `NFIFO_FLOWS; i++) begin : g_status
    status_bound: assert property (@(posedge clk) disable iff (!rst_n)
      status[i] <= nfifo_pkg::count_t'(`NFIFO_BLOCK_SIZE))
      else $error("status of flow %0d is %0d, above block size", i, status[i]);
  end

endmodule

/* fifo2nfifo_tb.sv */
/*
 * Directed testbench for the FIFO to multi-flow buffer
 * Per-flow reference queues, order, back-pressure and round-robin checks
 */

`timescale 1ns/10ps
`include "nfifo_defs.svh"

module fifo2nfifo_tb;

  // Cycle budget, reset then each test with its drain limit
  localparam int TEST_CYCLES = 6 + 2 + 47 + 51 + 66 + 99 + 58;
  localparam int DRAIN_LIMIT = 40;

  logic                   clk;
  logic                   rst_n;
  nfifo_pkg::wr_req_t     wr;
  logic                   full;
  nfifo_pkg::flow_mask_t  read;
  nfifo_pkg::data_vec_t   data_out;
  nfifo_pkg::flow_mask_t  data_vld;
  nfifo_pkg::flow_mask_t  empty;
  nfifo_pkg::status_vec_t status;

  // Expected words per flow, head leaves next
  nfifo_pkg::word_t      ref_q [`NFIFO_FLOWS][$];
  nfifo_pkg::flow_mask_t vld_seen;
  string                 cur_test;
  int                    err_count;
  int                    err_base;
  int                    test_count;
  integer                seed;

  fifo2nfifo u_fifo2nfifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .full     (full),
    .read     (read),
    .data_out (data_out),
    .data_vld (data_vld),
    .empty    (empty),
    .status   (status)
  );

  bind fifo2nfifo fifo2nfifo_properties u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .grant    (grant),
    .data_vld (data_vld),
    .empty    (empty),
    .status   (status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TEST_CYCLES * 20 * 2);
    $display("Watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_word(input string what, input nfifo_pkg::word_t exp,
                            input nfifo_pkg::word_t act);
    if (exp !== act) begin
      err_count++;
      $display("Fail %s: %s expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_mask(input string what, input nfifo_pkg::flow_mask_t exp,
                            input nfifo_pkg::flow_mask_t act);
    if (exp !== act) begin
      err_count++;
      $display("Fail %s: %s expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input nfifo_pkg::count_t exp,
                             input nfifo_pkg::count_t act);
    if (exp !== act) begin
      err_count++;
      $display("Fail %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      err_count++;
      $display("Fail %s: %s expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic nfifo_pkg::wr_req_t make_wr(input nfifo_pkg::flow_t flow);
    nfifo_pkg::wr_req_t w;
    w.data       = nfifo_pkg::word_t'($random(seed));
    w.block_addr = flow;
    w.write      = 1'b1;
    return w;
  endfunction

  // One clock: check what left the DUT, then drive the next inputs
  task automatic step(input nfifo_pkg::wr_req_t w, input nfifo_pkg::flow_mask_t rd);
    nfifo_pkg::flow_mask_t exp_empty;
    @(negedge clk);
    vld_seen = data_vld;
    for (int f = 0; f < `NFIFO_FLOWS; f++) begin
      if (data_vld[f] && ref_q[f].size() == 0) begin
        err_count++;
        $display("Flow %0d delivered a word that was never written", f);
      end else if (data_vld[f]) begin
        check_word("data_out", ref_q[f].pop_front(), data_out[f]);
      end
      // Queue length equals accepted writes minus grants
      check_count("status", nfifo_pkg::count_t'(ref_q[f].size()), status[f]);
      exp_empty[f] = (ref_q[f].size() == 0);
    end
    check_mask("empty", exp_empty, empty);
    wr   = w;
    read = rd;
    #1;
    if (w.write) begin
      check_flag("full", ref_q[w.block_addr].size() == `NFIFO_BLOCK_SIZE, full);
      if (ref_q[w.block_addr].size() < `NFIFO_BLOCK_SIZE) begin
        ref_q[w.block_addr].push_back(w.data);
      end
    end
  endtask

  // Hold read bits until the selected queues are used up
  task automatic drain(input nfifo_pkg::flow_mask_t mask);
    int cycles;
    bit pending;
    cycles  = 0;
    pending = 1'b1;
    while (pending && cycles < DRAIN_LIMIT) begin
      step('0, mask);
      cycles++;
      pending = 1'b0;
      for (int f = 0; f < `NFIFO_FLOWS; f++) begin
        if (mask[f] && ref_q[f].size() != 0) pending = 1'b1;
      end
    end
    if (pending) begin
      err_count++;
      $display("Timeout in %s, data_vld stopped while words were still queued", cur_test);
    end
    step('0, '0);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = err_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("test %-12s done, %0d errors", cur_test, err_count - err_base);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    begin_test("reset");
    step('0, '0);
    check_mask("data_vld", '0, vld_seen);
    check_mask("empty", '1, empty);
    end_test();
  endtask

  task automatic test_single_order();
    begin_test("single_flow");
    repeat (5) step(make_wr(2'd2), '0);
    drain(4'b0100);
    check_count("status", '0, status[2]);
    end_test();
  endtask

  task automatic test_full_block();
    begin_test("full_block");
    // Ninth word meets a full block and is dropped
    repeat (9) step(make_wr(2'd1), '0);
    check_count("status", nfifo_pkg::count_t'(`NFIFO_BLOCK_SIZE), status[1]);
    drain(4'b0010);
    end_test();
  endtask

  task automatic test_isolation();
    begin_test("isolation");
    repeat (24) step(make_wr(nfifo_pkg::flow_t'($random(seed))),
                     nfifo_pkg::flow_mask_t'($random(seed)));
    drain('1);
    end_test();
  endtask

  task automatic test_shared_port();
    int prev;
    int got;
    int cycles;
    int flow;
    begin_test("shared_port");
    for (int f = 0; f < `NFIFO_FLOWS; f++) begin
      repeat (4) step(make_wr(nfifo_pkg::flow_t'(f)), '0);
    end
    prev   = -1;
    got    = 0;
    cycles = 0;
    step('0, '1);
    // Equal loads, so the winner must rotate every cycle
    while (got < 4 * `NFIFO_FLOWS && cycles < DRAIN_LIMIT) begin
      step('0, '1);
      cycles++;
      if (!$onehot(vld_seen)) begin
        err_count++;
        $display("Read port idle or shared in one cycle, data_vld %b", vld_seen);
      end else begin
        for (int f = 0; f < `NFIFO_FLOWS; f++) begin
          if (vld_seen[f]) flow = f;
        end
        if (prev >= 0) begin
          check_mask("grant order", nfifo_pkg::flow_mask_t'(1) << ((prev + 1) % `NFIFO_FLOWS),
                     vld_seen);
        end
        prev = flow;
        got++;
      end
    end
    if (got < 4 * `NFIFO_FLOWS) begin
      err_count++;
      $display("Timeout in %s, only %0d words delivered", cur_test, got);
    end
    drain('1);
    end_test();
  endtask

  task automatic test_write_read();
    begin_test("write_read");
    repeat (4) step(make_wr(2'd3), '0);
    // Writes and grants together keep the count steady
    repeat (12) step(make_wr(2'd3), 4'b1000);
    drain(4'b1000);
    end_test();
  endtask

  initial begin
    seed       = 84;
    err_count  = 0;
    err_base   = 0;
    test_count = 0;
    cur_test   = "";
    vld_seen   = '0;
    rst_n      = 1'b0;
    wr         = '0;
    read       = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_single_order();
    test_full_block();
    test_isolation();
    test_shared_port();
    test_write_read();
    $display("Tests run: %0d, errors: %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+.
nfifo_pkg.sv
nfifo_buffer.sv
nfifo_ptr_ctrl.sv
nfifo_rd_arbiter.sv
fifo2nfifo.sv
fifo2nfifo_properties.sv
fifo2nfifo_tb.sv

/* nfifo_buffer.sv */
/*
 * Shared multi-flow buffer memory
 * One write port and one registered read port,
 * read data tagged with its flow number
 */

`timescale 1ns/10ps

module nfifo_buffer (
  input  logic                 clk,
  input  logic                 wr_en,
  input  nfifo_pkg::buf_addr_t wr_addr,
  input  nfifo_pkg::word_t     wr_data,
  input  logic                 rd_en,
  input  nfifo_pkg::buf_addr_t rd_addr,
  output nfifo_pkg::rd_resp_t  rd_resp
);

  // Flow number forms the upper address bits, so each flow owns one block
  localparam int DEPTH = 2 ** $bits(nfifo_pkg::buf_addr_t);

  nfifo_pkg::word_t mem [DEPTH];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------
  // Registered read port
  // ----------------------------------------
  // Same cell never read and written in one cycle, empty and full rule it out
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_resp.data <= mem[rd_addr];
      rd_resp.flow <= rd_addr.flow;
    end
  end

endmodule

/* nfifo_defs.svh */
/*
 * Multi-flow FIFO sizing constants
 * Word width, number of flows and words per flow block
 */

`ifndef NFIFO_DEFS_SVH
`define NFIFO_DEFS_SVH

// ----------------------------------------
// Buffer geometry
// ----------------------------------------

// Width of one flow word in bits
`define NFIFO_DATA_WIDTH 16

// Number of independent flows, power of two
`define NFIFO_FLOWS 4

// Words per flow block, power of two so pointers wrap on their own
`define NFIFO_BLOCK_SIZE 8

`endif

/* nfifo_pkg.sv */
/*
 * Multi-flow FIFO shared types
 * Words, flow numbers, buffer addresses and per-flow vectors
 */

`include "nfifo_defs.svh"

package nfifo_pkg;

  // Scalar types
  typedef logic [`NFIFO_DATA_WIDTH-1:0]           word_t;
  typedef logic [$clog2(`NFIFO_FLOWS)-1:0]        flow_t;
  typedef logic [$clog2(`NFIFO_BLOCK_SIZE)-1:0]   ptr_t;
  // Occupancy needs one more code for a full block
  typedef logic [$clog2(`NFIFO_BLOCK_SIZE+1)-1:0] count_t;
  typedef logic [`NFIFO_FLOWS-1:0]                flow_mask_t;

  // Write port request
  typedef struct packed {
    word_t data;
    flow_t block_addr;
    logic  write;
  } wr_req_t;

  // One cell of the shared buffer
  typedef struct packed {
    flow_t flow;
    ptr_t  ptr;
  } buf_addr_t;

  // Word leaving the buffer, tagged with its flow
  typedef struct packed {
    word_t data;
    flow_t flow;
  } rd_resp_t;

  // Per-flow vectors
  typedef count_t [`NFIFO_FLOWS-1:0] status_vec_t;
  typedef word_t  [`NFIFO_FLOWS-1:0] data_vec_t;

endpackage

/* nfifo_ptr_ctrl.sv */
/*
 * Multi-flow FIFO pointer control
 * Per-flow write/read pointers and occupancy counts,
 * write acceptance, full, empty and status flags
 */

`timescale 1ns/10ps

module nfifo_ptr_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  nfifo_pkg::wr_req_t     wr,
  input  nfifo_pkg::flow_mask_t  grant,
  input  nfifo_pkg::flow_mask_t  read,
  output nfifo_pkg::flow_mask_t  eligible,
  output logic                   full,
  output logic                   wr_en,
  output logic                   rd_en,
  output nfifo_pkg::buf_addr_t   wr_addr,
  output nfifo_pkg::buf_addr_t   rd_addr,
  output nfifo_pkg::flow_mask_t  empty,
  output nfifo_pkg::status_vec_t status
);

  localparam int FLOWS      = $bits(nfifo_pkg::flow_mask_t);
  localparam int BLOCK_SIZE = 2 ** $bits(nfifo_pkg::ptr_t);

  nfifo_pkg::ptr_t       wr_ptr [FLOWS];
  nfifo_pkg::ptr_t       rd_ptr [FLOWS];
  nfifo_pkg::count_t     cnt    [FLOWS];
  nfifo_pkg::flow_t      rd_flow;
  nfifo_pkg::flow_mask_t wr_hit;

  // ----------------------------------------
  // Write side
  // ----------------------------------------
  // Full refers to the block currently addressed
  assign full    = (cnt[wr.block_addr] == nfifo_pkg::count_t'(BLOCK_SIZE));
  assign wr_en   = wr.write && !full;
  assign wr_addr = '{flow: wr.block_addr, ptr: wr_ptr[wr.block_addr]};
  // One-hot of the flow taking a word this cycle
  assign wr_hit  = wr_en ? (nfifo_pkg::flow_mask_t'(1) << wr.block_addr) : '0;

  // ----------------------------------------
  // Read side
  // ----------------------------------------
  // Grant is one-hot, encode it to a flow number
  always_comb begin
    rd_flow = '0;
    for (int i = 0; i < FLOWS; i++) begin
      if (grant[i]) begin
        rd_flow = nfifo_pkg::flow_t'(i);
      end
    end
  end

  assign rd_en   = |grant;
  assign rd_addr = '{flow: rd_flow, ptr: rd_ptr[rd_flow]};

  // Flags straight from the counters
  always_comb begin
    for (int i = 0; i < FLOWS; i++) begin
      empty[i]  = (cnt[i] == '0);
      status[i] = cnt[i];
    end
  end

  // Requesting flows with data
  assign eligible = read & ~empty;

  // Pointer and count registers, all wrap inside the flow block
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < FLOWS; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        cnt[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < FLOWS; i++) begin
        if (wr_hit[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
        if (grant[i])  rd_ptr[i] <= rd_ptr[i] + 1'b1;
        // Write and grant together leave the count as is
        case ({wr_hit[i], grant[i]})
          2'b10:   cnt[i] <= cnt[i] + 1'b1;
          2'b01:   cnt[i] <= cnt[i] - 1'b1;
          default: cnt[i] <= cnt[i];
        endcase
      end
    end
  end

endmodule

/* nfifo_rd_arbiter.sv */
/*
 * Round-robin read port arbiter
 * One-hot grant per cycle, search starts after the last winner
 */

`timescale 1ns/10ps

module nfifo_rd_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  nfifo_pkg::flow_mask_t eligible,
  output nfifo_pkg::flow_mask_t grant
);

  localparam int FLOWS = $bits(nfifo_pkg::flow_mask_t);

  nfifo_pkg::flow_t last_q;
  nfifo_pkg::flow_t next_flow;
  logic             found;

  // ----------------------------------------
  // Grant search
  // ----------------------------------------
  // Walk the flows once, starting just past the last winner
  always_comb begin
    int idx;
    grant     = '0;
    next_flow = last_q;
    found     = 1'b0;
    for (int k = 1; k <= FLOWS; k++) begin
      idx = (int'(last_q) + k) % FLOWS;
      if (!found && eligible[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        next_flow  = nfifo_pkg::flow_t'(idx);
      end
    end
  end

  // ----------------------------------------
  // Last winner
  // ----------------------------------------
  // Starts at the last flow so flow 0 wins first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= nfifo_pkg::flow_t'(FLOWS - 1);
    end else if (found) begin
      last_q <= next_flow;
    end
  end

endmodule
